/* demux_pkg.sv */
// ------------------------------------------------
// Shared widths, port count, depths and the port
// select type of the write-side AXI demux
// ------------------------------------------------
`default_nettype none

package demux_pkg;

  // ------------------------------------------------
  // Master side
  // ------------------------------------------------
  localparam int unsigned N_MST = 3;
  localparam int unsigned SEL_W = 2;

  // Index of the target master port
  typedef logic [SEL_W-1:0] sel_t;

  // ------------------------------------------------
  // AXI channel widths
  // ------------------------------------------------
  localparam int unsigned ID_W   = 4;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // ------------------------------------------------
  // Ordering state
  // ------------------------------------------------
  // Low ID bits that pick a tracked ID
  localparam int unsigned LOOK_BITS = 2;
  localparam int unsigned N_IDS     = 4;

  // Outstanding counter, all ones means full
  localparam int unsigned CNT_W = 2;

  // Select FIFO between AW and W
  localparam int unsigned SEL_FIFO_DEPTH = 4;
  localparam int unsigned PTR_W          = $clog2(SEL_FIFO_DEPTH);

endpackage

`default_nettype wire

/* aw_router.sv */
// ------------------------------------------------
// AW router with per-ID outstanding counters,
// bound-port lookup and AW valid lock
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module aw_router (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Slave AW
  input  logic [demux_pkg::ID_W-1:0]    aw_id_i,
  input  logic [demux_pkg::ADDR_W-1:0]  aw_addr_i,
  input  demux_pkg::sel_t               aw_sel_i,
  input  logic                          aw_valid_i,
  output logic                          aw_ready_o,
  // Master AW
  output logic [demux_pkg::ID_W-1:0]    mst_aw_id_o,
  output logic [demux_pkg::ADDR_W-1:0]  mst_aw_addr_o,
  output logic [demux_pkg::N_MST-1:0]   mst_aw_valid_o,
  input  logic [demux_pkg::N_MST-1:0]   mst_aw_ready_i,
  // Select FIFO
  input  logic                          fifo_full_i,
  output logic                          sel_push_o,
  output demux_pkg::sel_t               sel_push_data_o,
  // Completed B at the slave port
  input  logic                          b_done_i,
  input  logic [demux_pkg::ID_W-1:0]    b_done_id_i
);
  import demux_pkg::*;

  logic [CNT_W-1:0]     cnt_q [N_IDS];
  sel_t                 bound_q [N_IDS];
  logic [N_IDS-1:0]     push_en;
  logic [N_IDS-1:0]     pop_en;
  logic [N_IDS-1:0]     cnt_full;
  logic [LOOK_BITS-1:0] aw_idx;
  logic [LOOK_BITS-1:0] done_idx;
  logic                 occupied;
  logic                 id_free;
  logic                 any_full;
  logic                 lock_q;
  logic                 lock_d;
  logic                 aw_valid;
  logic                 sel_ready;

  // ------------------------------------------------
  // ID lookup
  // ------------------------------------------------
  assign aw_idx   = aw_id_i[LOOK_BITS-1:0];
  assign done_idx = b_done_id_i[LOOK_BITS-1:0];

  always_comb begin
    for (int i = 0; i < N_IDS; i++) begin
      cnt_full[i] = &cnt_q[i];
      push_en[i]  = sel_push_o && (aw_idx == LOOK_BITS'(i));
      pop_en[i]   = b_done_i && (done_idx == LOOK_BITS'(i));
    end
  end

  assign any_full = |cnt_full;
  assign occupied = |cnt_q[aw_idx];
  // Same ID may only go on to the port it is already bound to
  assign id_free  = !occupied || (bound_q[aw_idx] == aw_sel_i);

  assign sel_ready = mst_aw_ready_i[aw_sel_i];

  // ------------------------------------------------
  // AW handshake
  // ------------------------------------------------
  always_comb begin
    aw_valid   = 1'b0;
    aw_ready_o = 1'b0;
    sel_push_o = 1'b0;
    lock_d     = lock_q;
    if (lock_q) begin
      // Decision already pushed, wait for the port
      aw_valid = 1'b1;
      if (sel_ready) begin
        aw_ready_o = 1'b1;
        lock_d     = 1'b0;
      end
    end else if (aw_valid_i && id_free && !any_full && !fifo_full_i) begin
      aw_valid   = 1'b1;
      sel_push_o = 1'b1;
      aw_ready_o = sel_ready;
      lock_d     = !sel_ready;
    end
  end

  always_comb begin
    for (int p = 0; p < N_MST; p++) begin
      mst_aw_valid_o[p] = aw_valid && (aw_sel_i == sel_t'(p));
    end
  end

  assign mst_aw_id_o     = aw_id_i;
  assign mst_aw_addr_o   = aw_addr_i;
  assign sel_push_data_o = aw_sel_i;

  // ------------------------------------------------
  // State
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // Push and pop on one ID cancel out
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < N_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_IDS; i++) begin
        if (push_en[i] && !pop_en[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (pop_en[i] && !push_en[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // Port bound to each tracked ID
  always_ff @(posedge clk_i) begin
    if (sel_push_o) begin
      bound_q[aw_idx] <= aw_sel_i;
    end
  end

endmodule

`default_nettype wire

/* w_select_fifo.sv */
// ------------------------------------------------
// Select FIFO, holds the target port of every
// accepted AW in order for the W channel
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module w_select_fifo (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            push_i,
  input  demux_pkg::sel_t data_i,
  input  logic            pop_i,
  output logic            full_o,
  output logic            empty_o,
  output demux_pkg::sel_t head_o
);
  import demux_pkg::*;

  sel_t             mem_q [SEL_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == (PTR_W+1)'(SEL_FIFO_DEPTH));
  assign empty_o = (count_q == '0);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Registered head, no fall-through
  assign head_o = mem_q[rd_ptr_q];

  // Pointers wrap naturally at a power-of-two depth
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* w_b_steer.sv */
// ------------------------------------------------
// W steering by the select FIFO head and
// round-robin B merge with lock-in
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module w_b_steer (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  // Select FIFO
  input  demux_pkg::sel_t                              sel_head_i,
  input  logic                                         sel_empty_i,
  output logic                                         sel_pop_o,
  // Slave W
  input  logic [demux_pkg::DATA_W-1:0]                 w_data_i,
  input  logic                                         w_last_i,
  input  logic                                         w_valid_i,
  output logic                                         w_ready_o,
  // Master W
  output logic [demux_pkg::DATA_W-1:0]                 mst_w_data_o,
  output logic                                         mst_w_last_o,
  output logic [demux_pkg::N_MST-1:0]                  mst_w_valid_o,
  input  logic [demux_pkg::N_MST-1:0]                  mst_w_ready_i,
  // Master B
  input  logic [demux_pkg::N_MST-1:0][demux_pkg::ID_W-1:0] mst_b_id_i,
  input  logic [demux_pkg::N_MST-1:0]                  mst_b_valid_i,
  output logic [demux_pkg::N_MST-1:0]                  mst_b_ready_o,
  // Slave B
  output logic [demux_pkg::ID_W-1:0]                   b_id_o,
  output logic                                         b_valid_o,
  input  logic                                         b_ready_i,
  // Completion to the router
  output logic                                         b_done_o,
  output logic [demux_pkg::ID_W-1:0]                   b_done_id_o
);
  import demux_pkg::*;

  sel_t rr_q;
  sel_t pick_q;
  sel_t pick;
  logic lock_q;
  logic found;

  // ------------------------------------------------
  // W channel
  // ------------------------------------------------
  assign mst_w_data_o = w_data_i;
  assign mst_w_last_o = w_last_i;

  always_comb begin
    mst_w_valid_o = '0;
    w_ready_o     = 1'b0;
    sel_pop_o     = 1'b0;
    // Nothing goes out until an AW has been routed
    if (!sel_empty_i) begin
      mst_w_valid_o[sel_head_i] = w_valid_i;
      w_ready_o                 = mst_w_ready_i[sel_head_i];
      sel_pop_o                 = w_valid_i && mst_w_ready_i[sel_head_i] && w_last_i;
    end
  end

  // ------------------------------------------------
  // B arbitration
  // ------------------------------------------------
  always_comb begin
    int unsigned cand;
    found = lock_q;
    pick  = lock_q ? pick_q : rr_q;
    cand  = 0;
    if (!lock_q) begin
      // Search starts at the port after the last grant
      for (int k = 0; k < N_MST; k++) begin
        cand = (int'(rr_q) + k) % N_MST;
        if (!found && mst_b_valid_i[cand]) begin
          found = 1'b1;
          pick  = sel_t'(cand);
        end
      end
    end
  end

  assign b_valid_o = found && mst_b_valid_i[pick];
  assign b_id_o    = mst_b_id_i[pick];

  always_comb begin
    mst_b_ready_o       = '0;
    mst_b_ready_o[pick] = b_valid_o && b_ready_i;
  end

  assign b_done_o    = b_valid_o && b_ready_i;
  assign b_done_id_o = b_id_o;

  // Grant is held while the slave stalls
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
    end else if (b_done_o) begin
      rr_q   <= (pick == sel_t'(N_MST - 1)) ? '0 : pick + 1'b1;
      lock_q <= 1'b0;
    end else if (b_valid_o) begin
      lock_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_valid_o && !b_ready_i) begin
      pick_q <= pick;
    end
  end

endmodule

`default_nettype wire

/* axi_wr_demux.sv */
// ------------------------------------------------
// Write-side AXI demux top level, one slave port
// to three master ports
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_wr_demux (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // Slave AW
  input  logic [demux_pkg::ID_W-1:0]                    slv_aw_id_i,
  input  logic [demux_pkg::ADDR_W-1:0]                  slv_aw_addr_i,
  input  demux_pkg::sel_t                               slv_aw_sel_i,
  input  logic                                          slv_aw_valid_i,
  output logic                                          slv_aw_ready_o,
  // Slave W
  input  logic [demux_pkg::DATA_W-1:0]                  slv_w_data_i,
  input  logic                                          slv_w_last_i,
  input  logic                                          slv_w_valid_i,
  output logic                                          slv_w_ready_o,
  // Slave B
  output logic [demux_pkg::ID_W-1:0]                    slv_b_id_o,
  output logic                                          slv_b_valid_o,
  input  logic                                          slv_b_ready_i,
  // Master AW
  output logic [demux_pkg::ID_W-1:0]                    mst_aw_id_o,
  output logic [demux_pkg::ADDR_W-1:0]                  mst_aw_addr_o,
  output logic [demux_pkg::N_MST-1:0]                   mst_aw_valid_o,
  input  logic [demux_pkg::N_MST-1:0]                   mst_aw_ready_i,
  // Master W
  output logic [demux_pkg::DATA_W-1:0]                  mst_w_data_o,
  output logic                                          mst_w_last_o,
  output logic [demux_pkg::N_MST-1:0]                   mst_w_valid_o,
  input  logic [demux_pkg::N_MST-1:0]                   mst_w_ready_i,
  // Master B
  input  logic [demux_pkg::N_MST-1:0][demux_pkg::ID_W-1:0] mst_b_id_i,
  input  logic [demux_pkg::N_MST-1:0]                   mst_b_valid_i,
  output logic [demux_pkg::N_MST-1:0]                   mst_b_ready_o
);
  import demux_pkg::*;

  logic            sel_push;
  sel_t            sel_push_data;
  logic            sel_full;
  logic            sel_empty;
  sel_t            sel_head;
  logic            sel_pop;
  logic            b_done;
  logic [ID_W-1:0] b_done_id;

  aw_router i_aw_router (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .aw_id_i         (slv_aw_id_i),
    .aw_addr_i       (slv_aw_addr_i),
    .aw_sel_i        (slv_aw_sel_i),
    .aw_valid_i      (slv_aw_valid_i),
    .aw_ready_o      (slv_aw_ready_o),
    .mst_aw_id_o     (mst_aw_id_o),
    .mst_aw_addr_o   (mst_aw_addr_o),
    .mst_aw_valid_o  (mst_aw_valid_o),
    .mst_aw_ready_i  (mst_aw_ready_i),
    .fifo_full_i     (sel_full),
    .sel_push_o      (sel_push),
    .sel_push_data_o (sel_push_data),
    .b_done_i        (b_done),
    .b_done_id_i     (b_done_id)
  );

  w_select_fifo i_sel_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (sel_push),
    .data_i  (sel_push_data),
    .pop_i   (sel_pop),
    .full_o  (sel_full),
    .empty_o (sel_empty),
    .head_o  (sel_head)
  );

  w_b_steer i_w_b_steer (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .sel_head_i    (sel_head),
    .sel_empty_i   (sel_empty),
    .sel_pop_o     (sel_pop),
    .w_data_i      (slv_w_data_i),
    .w_last_i      (slv_w_last_i),
    .w_valid_i     (slv_w_valid_i),
    .w_ready_o     (slv_w_ready_o),
    .mst_w_data_o  (mst_w_data_o),
    .mst_w_last_o  (mst_w_last_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_ready_i (mst_w_ready_i),
    .mst_b_id_i    (mst_b_id_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_ready_o (mst_b_ready_o),
    .b_id_o        (slv_b_id_o),
    .b_valid_o     (slv_b_valid_o),
    .b_ready_i     (slv_b_ready_i),
    .b_done_o      (b_done),
    .b_done_id_o   (b_done_id)
  );

endmodule

`default_nettype wire

/* axi_wr_demux_chk.sv */
// ------------------------------------------------
// Protocol assertions on AW routing and on valid
// stability, bound into the demux top level
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi_wr_demux_chk (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic [demux_pkg::ID_W-1:0]    slv_aw_id_i,
  input logic [demux_pkg::ADDR_W-1:0]  slv_aw_addr_i,
  input demux_pkg::sel_t               slv_aw_sel_i,
  input logic [demux_pkg::ID_W-1:0]    mst_aw_id_o,
  input logic [demux_pkg::ADDR_W-1:0]  mst_aw_addr_o,
  input logic [demux_pkg::N_MST-1:0]   mst_aw_valid_o,
  input logic [demux_pkg::N_MST-1:0]   mst_aw_ready_i,
  input logic [demux_pkg::ID_W-1:0]    slv_b_id_o,
  input logic                          slv_b_valid_o,
  input logic                          slv_b_ready_i
);
  import demux_pkg::*;

  int unsigned fail_cnt = 0;

  // One-hot valid on the selected port, ID and address replicated
  aw_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_aw_valid_o != '0) |-> ((mst_aw_valid_o == (N_MST'(1) << slv_aw_sel_i)) &&
      (mst_aw_id_o == slv_aw_id_i) && (mst_aw_addr_o == slv_aw_addr_i)))
    else begin
      fail_cnt++;
      $error("AW valid not routed to the selected port");
    end

  // A stalled port keeps its valid bit
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((mst_aw_valid_o & ~mst_aw_ready_i) != '0) |=>
      ((mst_aw_valid_o & $past(mst_aw_valid_o & ~mst_aw_ready_i)) ==
       $past(mst_aw_valid_o & ~mst_aw_ready_i)))
    else begin
      fail_cnt++;
      $error("AW valid dropped before the port accepted it");
    end

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_b_valid_o && !slv_b_ready_i) |=> (slv_b_valid_o && $stable(slv_b_id_o)))
    else begin
      fail_cnt++;
      $error("B valid or ID changed while the slave stalled");
    end

endmodule

bind axi_wr_demux axi_wr_demux_chk chk_i (.*);

`default_nettype wire

/* tb_axi_wr_demux.sv */
// ------------------------------------------------
// Testbench for the write-side AXI demux with
// master port models, scoreboard and watchdog
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_demux;
  import demux_pkg::*;

  localparam int unsigned CLK_PERIOD = 100;
  localparam int unsigned N_RAND     = 40;
  // Random run plus the three directed tests
  localparam int unsigned N_TXN      = N_RAND + 2 + 4 + 4;

  logic                         clk_i;
  logic                         rst_n_i;
  logic [ID_W-1:0]              slv_aw_id_i;
  logic [ADDR_W-1:0]            slv_aw_addr_i;
  sel_t                         slv_aw_sel_i;
  logic                         slv_aw_valid_i;
  logic                         slv_aw_ready_o;
  logic [DATA_W-1:0]            slv_w_data_i;
  logic                         slv_w_last_i;
  logic                         slv_w_valid_i;
  logic                         slv_w_ready_o;
  logic [ID_W-1:0]              slv_b_id_o;
  logic                         slv_b_valid_o;
  logic                         slv_b_ready_i;
  logic [ID_W-1:0]              mst_aw_id_o;
  logic [ADDR_W-1:0]            mst_aw_addr_o;
  logic [N_MST-1:0]             mst_aw_valid_o;
  logic [N_MST-1:0]             mst_aw_ready_i;
  logic [DATA_W-1:0]            mst_w_data_o;
  logic                         mst_w_last_o;
  logic [N_MST-1:0]             mst_w_valid_o;
  logic [N_MST-1:0]             mst_w_ready_i;
  logic [N_MST-1:0][ID_W-1:0]   mst_b_id_i;
  logic [N_MST-1:0]             mst_b_valid_i;
  logic [N_MST-1:0]             mst_b_ready_o;

  // Pending AWs, W bursts and expected W targets
  int unsigned     aw_id_q[$];
  int unsigned     aw_sel_q[$];
  int unsigned     aw_len_q[$];
  int unsigned     w_len_q[$];
  int unsigned     exp_sel_q[$];
  // B responses owed by each port model
  logic [ID_W-1:0] bq [N_MST][$];
  int unsigned     b_pend [2**ID_W];

  int unsigned      cur_len;
  int unsigned      w_len;
  int unsigned      w_beat;
  int unsigned      aw_acc;
  int               b_open;
  int               grant;
  int               prev_grant;
  int unsigned      errors;
  int unsigned      test_base;
  int unsigned      n_tests;
  logic             aw_fire;
  logic             w_fire;
  logic             b_fire;
  logic [N_MST-1:0] b_pop;
  logic [N_MST-1:0] b_hold;
  logic             rdy_rand;
  logic             aw_stall;
  logic             alt_check;
  logic             have_prev;

  axi_wr_demux dut_i (.*);

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  task automatic fail_value(string name, logic [63:0] got, logic [63:0] exp);
    $display("Fail %s: got %0h, expected %0h", name, got, exp);
    errors++;
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic issue(int unsigned id, int unsigned sel, int unsigned len);
    aw_id_q.push_back(id);
    aw_sel_q.push_back(sel);
    aw_len_q.push_back(len);
  endtask

  task automatic wait_accepted(int unsigned n);
    while (aw_acc < n) next_cycle();
  endtask

  // Everything issued has gone through AW, W and B
  task automatic drain();
    while (aw_id_q.size() != 0 || slv_aw_valid_i || w_len_q.size() != 0 ||
           slv_w_valid_i || exp_sel_q.size() != 0 || b_open != 0) begin
      next_cycle();
    end
  endtask

  task automatic end_test(string name);
    int unsigned total;
    total = errors + dut_i.chk_i.fail_cnt;
    $display("Test %-18s %s, %0d errors", name, total == test_base ? "ok" : "failed",
             total - test_base);
    test_base = total;
    n_tests++;
  endtask

  // ------------------------------------------------
  // Monitor and scoreboard sampled at the rising edge
  // ------------------------------------------------
  always @(posedge clk_i) begin
    aw_fire = rst_n_i && slv_aw_valid_i && slv_aw_ready_o;
    w_fire  = rst_n_i && slv_w_valid_i && slv_w_ready_o;
    b_fire  = rst_n_i && slv_b_valid_o && slv_b_ready_i;
    for (int p = 0; p < N_MST; p++) begin
      b_pop[p] = rst_n_i && mst_b_valid_i[p] && mst_b_ready_o[p];
      if (mst_b_ready_o[p]) grant = p;
      if (rst_n_i && mst_aw_valid_o[p] && mst_aw_ready_i[p]) begin
        bq[p].push_back(mst_aw_id_o);
        b_pend[mst_aw_id_o]++;
        b_open++;
      end
      if (b_pop[p]) void'(bq[p].pop_front());
    end
    if (aw_fire) begin
      exp_sel_q.push_back(slv_aw_sel_i);
      w_len_q.push_back(cur_len);
      aw_acc++;
    end
    if (aw_stall) begin
      assert (mst_aw_valid_o == '0) else fail_value("mst_aw_valid_o", mst_aw_valid_o, 0);
      assert (!slv_aw_ready_o) else fail_value("slv_aw_ready_o", slv_aw_ready_o, 0);
    end
    if (w_fire) begin
      if (exp_sel_q.size() == 0) begin
        $display("A W beat was transferred before any AW was accepted");
        errors++;
      end else begin
        assert (mst_w_valid_o == (N_MST'(1) << exp_sel_q[0]))
          else fail_value("mst_w_valid_o", mst_w_valid_o, N_MST'(1) << exp_sel_q[0]);
        if (slv_w_last_i) void'(exp_sel_q.pop_front());
      end
      // Data and last are replicated to every port
      assert (mst_w_data_o == slv_w_data_i)
        else fail_value("mst_w_data_o", mst_w_data_o, slv_w_data_i);
      assert (mst_w_last_o == (w_beat + 1 == w_len))
        else fail_value("mst_w_last_o", mst_w_last_o, w_beat + 1 == w_len);
    end
    if (b_fire) begin
      assert ($onehot(b_pop)) else begin
        $display("B transfer at the slave was not taken from exactly one port");
        errors++;
      end
      assert (b_pend[slv_b_id_o] != 0) else begin
        $display("B response with ID %0h was never issued by a port", slv_b_id_o);
        errors++;
      end
      if (b_pend[slv_b_id_o] != 0) b_pend[slv_b_id_o]--;
      b_open--;
      if (alt_check && have_prev) begin
        assert (grant != prev_grant) else begin
          $display("B grant stayed on port %0d instead of alternating", grant);
          errors++;
        end
      end
      prev_grant = grant;
      have_prev  = 1'b1;
      aw_stall   = 1'b0;
    end else if (b_pop != '0) begin
      $display("A port handed over a B response that the slave did not take");
      errors++;
    end
  end

  // ------------------------------------------------
  // Slave driver and port models on the falling edge
  // ------------------------------------------------
  always @(negedge clk_i) begin
    if (!slv_aw_valid_i || aw_fire) begin
      slv_aw_valid_i = (aw_id_q.size() != 0);
      if (aw_id_q.size() != 0) begin
        slv_aw_id_i   = ID_W'(aw_id_q.pop_front());
        slv_aw_sel_i  = sel_t'(aw_sel_q.pop_front());
        slv_aw_addr_i = $urandom;
        cur_len       = aw_len_q.pop_front();
      end
    end
    if (w_fire) w_beat++;
    if (!slv_w_valid_i || w_fire) begin
      if (w_beat >= w_len && w_len_q.size() != 0) begin
        w_len  = w_len_q.pop_front();
        w_beat = 0;
      end
      slv_w_valid_i = (w_beat < w_len);
      slv_w_last_i  = (w_beat + 1 == w_len);
      slv_w_data_i  = $urandom;
    end
    for (int p = 0; p < N_MST; p++) begin
      mst_aw_ready_i[p] = rdy_rand ? 1'($urandom) : 1'b1;
      mst_w_ready_i[p]  = rdy_rand ? 1'($urandom) : 1'b1;
      if (!mst_b_valid_i[p] || b_pop[p]) begin
        mst_b_valid_i[p] = (bq[p].size() != 0) && !b_hold[p];
        mst_b_id_i[p]    = (bq[p].size() != 0) ? bq[p][0] : '0;
      end
    end
    slv_b_ready_i = rdy_rand ? 1'($urandom) : 1'b1;
  end

  initial begin
    #((N_TXN * 40 + 200) * CLK_PERIOD);
    $display("Watchdog expired, the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial begin
    void'($urandom(26));
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_sel_i   = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_data_i   = '0;
    slv_w_last_i   = 1'b0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    mst_aw_ready_i = '0;
    mst_w_ready_i  = '0;
    mst_b_id_i     = '0;
    mst_b_valid_i  = '0;
    {aw_fire, w_fire, b_fire, b_pop, b_hold} = '0;
    {rdy_rand, aw_stall, alt_check, have_prev} = '0;
    {cur_len, w_len, w_beat, aw_acc, b_open, grant, prev_grant} = '0;
    {errors, test_base, n_tests} = '0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    next_cycle();

    rdy_rand = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      issue($urandom % (2**ID_W), $urandom % N_MST, 1 + $urandom % 3);
    end
    drain();
    rdy_rand = 1'b0;
    end_test("random traffic");

    // ID 1 bound to port 0 while its B is held
    b_hold = 3'b001;
    issue(1, 0, 2);
    wait_accepted(aw_acc + 1);
    aw_stall = 1'b1;
    issue(1, 2, 1);
    repeat (8) next_cycle();
    b_hold = '0;
    drain();
    end_test("same id order");

    b_hold = 3'b010;
    repeat (3) issue(2, 1, 1 + $urandom % 3);
    wait_accepted(aw_acc + 3);
    aw_stall = 1'b1;
    issue(2, 1, 1);
    repeat (8) next_cycle();
    b_hold = '0;
    drain();
    end_test("outstanding limit");

    // Ports 0 and 1 release their responses together
    b_hold = 3'b011;
    issue(0, 0, 1);
    issue(3, 1, 1);
    issue(0, 0, 1);
    issue(3, 1, 1);
    wait_accepted(aw_acc + 4);
    have_prev = 1'b0;
    alt_check = 1'b1;
    b_hold    = '0;
    drain();
    alt_check = 1'b0;
    end_test("b merge");

    $display("Tests run: %0d, testbench errors: %0d, assertion errors: %0d",
             n_tests, errors, dut_i.chk_i.fail_cnt);
    if (errors == 0 && dut_i.chk_i.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
demux_pkg.sv
aw_router.sv
w_select_fifo.sv
w_b_steer.sv
axi_wr_demux.sv
axi_wr_demux_chk.sv
tb_axi_wr_demux.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the AXI write demux testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_axi_wr_demux -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_axi_wr_demux +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
exit 0
